/* hw/csr_index_defines.svh */
// ------------------------------------------------------------
// Widths, sequence length and FIFO sizing for the CSR index
// configuration capture
// ------------------------------------------------------------

`ifndef CSR_INDEX_DEFINES_SVH
`define CSR_INDEX_DEFINES_SVH

// Memory response fields
`define CSR_DATA_W 32
`define CSR_OFFSET_W 16

// Words per configuration sequence
`define CSR_SEQ_LEN 8

// Narrow configuration fields
`define CSR_GRAN_W 6
`define CSR_MASK_W 4

// Configuration FIFO
`define CSR_FIFO_DEPTH 16
`define CSR_FIFO_PROG_THRESH 8

`endif

/* hw/csr_index_pkg.sv */
// ------------------------------------------------------------
// Shared packed types for the CSR index configuration path
// ------------------------------------------------------------

`include "csr_index_defines.svh"

package csr_index_pkg;

    // One memory response word
    typedef struct packed {
        logic                     valid;
        logic [`CSR_OFFSET_W-1:0] offset;
        logic [`CSR_DATA_W-1:0]   data;
    } memory_response_t;

    // Word inside the window, slot is one-hot
    typedef struct packed {
        logic                    valid;
        logic [`CSR_SEQ_LEN-1:0] slot;
        logic [`CSR_DATA_W-1:0]  data;
    } config_word_t;

    typedef struct packed {
        logic                   increment;
        logic                   decrement;
        logic                   mode_sequence;
        logic                   mode_buffer;
        logic                   mode_break;
        logic [`CSR_DATA_W-1:0] index_start;
        logic [`CSR_DATA_W-1:0] index_end;
        logic [`CSR_DATA_W-1:0] stride;
        logic [`CSR_GRAN_W-1:0] granularity;
        logic                   direction;
        logic [`CSR_DATA_W-1:0] array_size;
        logic [`CSR_DATA_W-1:0] const_value;
        logic [`CSR_MASK_W-1:0] const_mask;
    } csr_index_config_t;

    typedef struct packed {
        logic              valid;
        csr_index_config_t payload;
    } csr_index_config_out_t;

    typedef struct packed {
        logic empty;
        logic full;
        logic prog_full;
    } fifo_status_t;

endpackage

/* hw/response_window_filter.sv */
// ------------------------------------------------------------
// Response input register and offset window test
// ------------------------------------------------------------

`timescale 1ns/10ps
`include "csr_index_defines.svh"

module response_window_filter #(
    parameter int id_relative = 0
) (
    input  logic                            ap_clk,
    input  logic                            areset_csr_index_generator,
    input  csr_index_pkg::memory_response_t response_in,
    output csr_index_pkg::config_word_t     accepted_word
);
    import csr_index_pkg::*;

    // Window covers one full sequence of this engine
    localparam logic [`CSR_OFFSET_W-1:0] win_base =
        `CSR_OFFSET_W'(id_relative * `CSR_SEQ_LEN);
    localparam logic [`CSR_OFFSET_W-1:0] win_last =
        win_base + `CSR_OFFSET_W'(`CSR_SEQ_LEN - 1);

    memory_response_t resp_q;
    logic             in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            resp_q.valid <= 1'b0;
        end else begin
            resp_q.valid <= response_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_q.offset <= response_in.offset;
        resp_q.data   <= response_in.data;
    end

    assign in_window = (resp_q.offset >= win_base) && (resp_q.offset <= win_last);

    // Slot bit 0 flags the word that opens a sequence
    assign accepted_word.valid = resp_q.valid & in_window;
    assign accepted_word.slot  = {{(`CSR_SEQ_LEN-1){1'b0}}, resp_q.offset == win_base};
    assign accepted_word.data  = resp_q.data;

endmodule

/* hw/config_word_sequencer.sv */
// ------------------------------------------------------------
// One-hot slot tracking for a configuration sequence
// and the sequence-done pulse
// ------------------------------------------------------------

`timescale 1ns/10ps
`include "csr_index_defines.svh"

module config_word_sequencer (
    input  logic                        ap_clk,
    input  logic                        areset_csr_index_generator,
    input  csr_index_pkg::config_word_t accepted_word,
    output csr_index_pkg::config_word_t slot_word,
    output logic                        sequence_done
);

    logic [`CSR_SEQ_LEN-1:0] slot_q;
    logic [`CSR_SEQ_LEN-1:0] slot_next;
    logic                    seq_idle;
    logic                    take_word;

    // Last slot counts as idle, it clears on the next edge
    assign seq_idle  = (slot_q == '0) | slot_q[`CSR_SEQ_LEN-1];
    assign take_word = accepted_word.valid & (~seq_idle | accepted_word.slot[0]);

    always_comb begin
        slot_next = slot_q;
        if (accepted_word.valid) begin
            if (seq_idle) begin
                slot_next = accepted_word.slot[0] ? `CSR_SEQ_LEN'(1) : '0;
            end else begin
                slot_next = slot_q << 1;
            end
        end else if (slot_q[`CSR_SEQ_LEN-1]) begin
            slot_next = '0;
        end
    end

    // ------------------------------------------------------------
    // Slot state and done pulse
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            slot_q          <= '0;
            slot_word.valid <= 1'b0;
            sequence_done   <= 1'b0;
        end else begin
            slot_q          <= slot_next;
            slot_word.valid <= take_word;
            sequence_done   <= slot_q[`CSR_SEQ_LEN-1];
        end
    end

    // Payload follows the new slot value
    always_ff @(posedge ap_clk) begin
        slot_word.slot <= slot_next;
        slot_word.data <= accepted_word.data;
    end

    // Start word only when no sequence is running
    a_start_when_idle: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        accepted_word.valid && accepted_word.slot[0] |-> seq_idle);

endmodule

/* hw/config_field_decoder.sv */
// ------------------------------------------------------------
// Places each slot's data word into the configuration record
// ------------------------------------------------------------

`timescale 1ns/10ps
`include "csr_index_defines.svh"

module config_field_decoder (
    input  logic                             ap_clk,
    input  csr_index_pkg::config_word_t      slot_word,
    output csr_index_pkg::csr_index_config_t config_record
);

    // ------------------------------------------------------------
    // Field capture
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (slot_word.valid) begin
            case (1'b1)
                slot_word.slot[0]: begin
                    // Mode flags in the low bits
                    config_record.increment     <= slot_word.data[0];
                    config_record.decrement     <= slot_word.data[1];
                    config_record.mode_sequence <= slot_word.data[2];
                    config_record.mode_buffer   <= slot_word.data[3];
                    config_record.mode_break    <= slot_word.data[4];
                end
                slot_word.slot[1]: begin
                    config_record.index_start <= slot_word.data;
                end
                slot_word.slot[2]: begin
                    config_record.index_end <= slot_word.data;
                end
                slot_word.slot[3]: begin
                    config_record.stride <= slot_word.data;
                end
                slot_word.slot[4]: begin
                    // Shift amount low, direction in the top bit
                    config_record.granularity <= slot_word.data[`CSR_GRAN_W-1:0];
                    config_record.direction   <= slot_word.data[`CSR_DATA_W-1];
                end
                slot_word.slot[5]: begin
                    config_record.array_size <= slot_word.data;
                end
                slot_word.slot[6]: begin
                    config_record.const_value <= slot_word.data;
                end
                slot_word.slot[7]: begin
                    config_record.const_mask <= slot_word.data[`CSR_MASK_W-1:0];
                end
                default: begin
                    config_record <= config_record;
                end
            endcase
        end
    end

    // Sequencer must never hand over a word without a slot
    a_valid_has_slot: assert property (@(posedge ap_clk)
        slot_word.valid |-> $onehot(slot_word.slot));

endmodule

/* hw/config_fifo.sv */
// ------------------------------------------------------------
// Synchronous FIFO for configuration records with status
// flags and a reset-busy setup flag
// ------------------------------------------------------------

`timescale 1ns/10ps
`include "csr_index_defines.svh"

module config_fifo #(
    parameter type payload_t = csr_index_pkg::csr_index_config_t
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_index_generator,
    input  logic                                 wr_en,
    input  payload_t                             din,
    input  logic                                 rd_en,
    output csr_index_pkg::csr_index_config_out_t dout,
    output csr_index_pkg::fifo_status_t          status,
    output logic                                 setup
);

    localparam int ptr_w = $clog2(`CSR_FIFO_DEPTH);
    localparam int cnt_w = $clog2(`CSR_FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`CSR_FIFO_DEPTH - 1);

    payload_t               mem [`CSR_FIFO_DEPTH];
    payload_t               rd_data_q;
    logic                   rd_valid_q;
    logic [ptr_w-1:0]       wr_ptr_q;
    logic [ptr_w-1:0]       rd_ptr_q;
    logic [cnt_w-1:0]       count_q;
    logic                   push;
    logic                   pop;

    // Nothing moves while the buffer comes out of reset
    assign push = wr_en & ~status.full & ~setup;
    assign pop  = rd_en & ~status.empty & ~setup;

    // ------------------------------------------------------------
    // Pointers, count and setup flag
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            rd_valid_q <= 1'b0;
            setup      <= 1'b1;
        end else begin
            setup      <= 1'b0;
            rd_valid_q <= pop;
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr_q] <= din;
        end
        if (pop) begin
            rd_data_q <= mem[rd_ptr_q];
        end
    end

    assign dout.valid   = rd_valid_q;
    assign dout.payload = rd_data_q;

    assign status.empty     = (count_q == '0);
    assign status.full      = (count_q == cnt_w'(`CSR_FIFO_DEPTH));
    assign status.prog_full = (count_q >= cnt_w'(`CSR_FIFO_PROG_THRESH));

    // A record offered to a full buffer is lost
    a_no_write_when_full: assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        wr_en |-> !status.full);

endmodule

/* hw/csr_index_configure_memory.sv */
// ------------------------------------------------------------
// CSR index configuration capture, top level
// ------------------------------------------------------------

`timescale 1ns/10ps

module csr_index_configure_memory #(
    parameter int id_relative = 0
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_csr_index_generator,
    input  csr_index_pkg::memory_response_t      response_in,
    input  logic                                 config_rd_en,
    output csr_index_pkg::csr_index_config_out_t config_out,
    output csr_index_pkg::fifo_status_t          fifo_status,
    output logic                                 fifo_setup
);
    import csr_index_pkg::*;

    config_word_t      accepted_word;
    config_word_t      slot_word;
    logic              sequence_done;
    csr_index_config_t config_record;

    response_window_filter #(
        .id_relative(id_relative)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .accepted_word             (accepted_word)
    );

    config_word_sequencer u_sequencer (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .accepted_word             (accepted_word),
        .slot_word                 (slot_word),
        .sequence_done             (sequence_done)
    );

    config_field_decoder u_decoder (
        .ap_clk       (ap_clk),
        .slot_word    (slot_word),
        .config_record(config_record)
    );

    // Done pulse pushes the finished record
    config_fifo #(
        .payload_t(csr_index_config_t)
    ) u_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (sequence_done),
        .din                       (config_record),
        .rd_en                     (config_rd_en),
        .dout                      (config_out),
        .status                    (fifo_status),
        .setup                     (fifo_setup)
    );

endmodule

/* verif/tb_csr_index_configure_memory.sv */
// ------------------------------------------------------------
// Testbench for the CSR index configuration capture with
// LCG stimulus, reference record model and output checker
// ------------------------------------------------------------

`timescale 1ns/10ps
`include "csr_index_defines.svh"

module tb_csr_index_configure_memory;
    import csr_index_pkg::*;

    localparam int id_relative = 2;
    localparam logic [`CSR_OFFSET_W-1:0] win_base = `CSR_OFFSET_W'(id_relative * `CSR_SEQ_LEN);
    // 22 sequences of at most about 40 cycles each, doubled with margin
    localparam int max_cycles = 2000;

    logic                  ap_clk;
    logic                  areset_csr_index_generator;
    memory_response_t      response_in;
    logic                  config_rd_en;
    csr_index_config_out_t config_out;
    fifo_status_t          fifo_status;
    logic                  fifo_setup;

    csr_index_config_t expected_q[$];
    csr_index_config_t exp_rec;
    logic [31:0]       rng_state;
    int                cycle_count;

    csr_index_configure_memory #(
        .id_relative(id_relative)
    ) uut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .config_rd_en              (config_rd_en),
        .config_out                (config_out),
        .fifo_status               (fifo_status),
        .fifo_setup                (fifo_setup)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Stimulus helpers and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = lcg_next(rng_state);
        value = rng_state;
    endtask

    // Expected record from the eight words of one sequence
    function automatic csr_index_config_t build_expected(input logic [31:0] words [8]);
        csr_index_config_t rec;
        rec.increment     = words[0][0];
        rec.decrement     = words[0][1];
        rec.mode_sequence = words[0][2];
        rec.mode_buffer   = words[0][3];
        rec.mode_break    = words[0][4];
        rec.index_start   = words[1];
        rec.index_end     = words[2];
        rec.stride        = words[3];
        rec.granularity   = words[4][5:0];
        rec.direction     = words[4][31];
        rec.array_size    = words[5];
        rec.const_value   = words[6];
        rec.const_mask    = words[7][3:0];
        return rec;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic send_word(input logic [15:0] offset, input logic [31:0] data);
        @(posedge ap_clk);
        #2;
        response_in.valid  = 1'b1;
        response_in.offset = offset;
        response_in.data   = data;
    endtask

    task automatic end_words();
        @(posedge ap_clk);
        #2;
        response_in.valid = 1'b0;
    endtask

    // Out-of-window words land at offsets 0..7 or 24..31
    task automatic send_sequence(input bit interleave);
        logic [31:0] words [8];
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            draw_random(words[i]);
        end
        expected_q.push_back(build_expected(words));
        for (int i = 0; i < 8; i++) begin
            if (interleave) begin
                draw_random(r);
                if (r[20]) begin
                    send_word(r[16] ? 16'(r[2:0]) : 16'd24 + 16'(r[5:3]), r);
                end
            end
            send_word(win_base + 16'(i), words[i]);
        end
        end_words();
    endtask

    // Last word reaches the FIFO three edges after it is sampled
    task automatic settle_pipeline();
        repeat (4) @(posedge ap_clk);
        #2;
    endtask

    task automatic drain_fifo(input bit single_pulse);
        @(posedge ap_clk);
        #2;
        config_rd_en = 1'b1;
        if (single_pulse) begin
            @(posedge ap_clk);
            #2;
            config_rd_en = 1'b0;
        end
        while (expected_q.size() != 0) begin
            @(posedge ap_clk);
        end
        #2;
        config_rd_en = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Output compare and timeout
    // ------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && config_out.valid) begin
            if (expected_q.size() == 0) begin
                $display("Output record at %0t arrived with none expected", $time);
                $display("tests failed");
                $fatal(1, "unexpected output record");
            end else begin
                exp_rec = expected_q.pop_front();
                check_value("config_out.payload", 256'(config_out.payload), 256'(exp_rec));
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("tests failed");
            $display("Run did not finish within %0d cycles", max_cycles);
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] r;
        cycle_count                = 0;
        rng_state                  = 32'd58511;
        areset_csr_index_generator = 1'b1;
        response_in                = '0;
        config_rd_en               = 1'b0;
        repeat (10) @(posedge ap_clk);
        #2;
        check_value("fifo_setup", 256'(fifo_setup), 256'(1'b1));
        areset_csr_index_generator = 1'b0;

        // Reset state
        check_value("fifo_status.empty", 256'(fifo_status.empty), 256'(1'b1));
        check_value("config_out.valid", 256'(config_out.valid), 256'(1'b0));
        repeat (2) @(posedge ap_clk);
        #2;
        check_value("fifo_setup", 256'(fifo_setup), 256'(1'b0));

        // Single clean sequence, one read pulse
        send_sequence(1'b0);
        settle_pipeline();
        drain_fifo(1'b1);

        // Stray offsets mixed into a sequence
        send_sequence(1'b1);
        settle_pipeline();
        drain_fifo(1'b0);

        // Window words without a start word
        for (int i = 1; i < 8; i++) begin
            draw_random(r);
            send_word(win_base + 16'(i), r);
        end
        end_words();
        settle_pipeline();
        check_value("fifo_status.empty", 256'(fifo_status.empty), 256'(1'b1));

        // Back-pressure with five records
        for (int i = 0; i < 5; i++) begin
            send_sequence(1'b0);
        end
        settle_pipeline();
        check_value("fifo_status.prog_full", 256'(fifo_status.prog_full), 256'(1'b0));
        check_value("fifo_status.empty", 256'(fifo_status.empty), 256'(1'b0));
        drain_fifo(1'b0);

        // Fifteen records held, past the prog_full level
        for (int i = 0; i < 15; i++) begin
            send_sequence(i[0]);
        end
        settle_pipeline();
        check_value("fifo_status.prog_full", 256'(fifo_status.prog_full), 256'(1'b1));
        check_value("fifo_status.full", 256'(fifo_status.full), 256'(1'b0));
        drain_fifo(1'b0);
        settle_pipeline();
        check_value("fifo_status.empty", 256'(fifo_status.empty), 256'(1'b1));

        if (expected_q.size() != 0) begin
            $display("%0d expected records never came out", expected_q.size());
            $display("tests failed");
            $fatal(1, "missing output records");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

/* csr_index_configure_memory.f */
+incdir+hw
hw/csr_index_pkg.sv
hw/response_window_filter.sv
hw/config_word_sequencer.sv
hw/config_field_decoder.sv
hw/config_fifo.sv
hw/csr_index_configure_memory.sv
verif/tb_csr_index_configure_memory.sv

/* Makefile */
TOP = tb_csr_index_configure_memory

simulate:
	verilator --binary --timing --assert -f csr_index_configure_memory.f \
		--top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: simulate clean
